// File: include/ipod_defs.svh
`ifndef IPOD_DEFS_SVH
`define IPOD_DEFS_SVH

// ============================================================
// Bus widths
// ============================================================
`define IPOD_ADDR_W 23
`define IPOD_DATA_W 32
`define IPOD_PERIOD_W 16

// ============================================================
// Playback rate, in CLK_50M cycles per sample
// ============================================================
`define IPOD_DEFAULT_PERIOD 614
`define IPOD_SPEED_STEP 10
`define IPOD_MIN_PERIOD 64
`define IPOD_MAX_PERIOD 4000

// Key event window, 100 ms
`define IPOD_EVENT_CYCLES 5000000
// Display refresh, 2 Hz
`define IPOD_REFRESH_CYCLES 25000000

`endif

// File: project.f
+incdir+include
source/ipod_pkg.sv
source/key_event_gen.sv
source/speed_ctrl.sv
source/sample_tick_gen.sv
source/flash_sample_reader.sv
source/hex_period_display.sv
source/ipod_top.sv
verif/ipod_assert.sv
verif/ipod_tb.sv

// File: source/flash_sample_reader.sv
`timescale 1ns/1ps

module flash_sample_reader #(
  parameter ipod_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    sample_tick,
  input  logic                    reverse,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  ipod_pkg::flash_word_t   flash_readdata,
  output logic                    flash_read,
  output ipod_pkg::flash_addr_t   flash_address,
  output ipod_pkg::audio_sample_t audio_sample
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } rd_state_t;

  rd_state_t state;
  ipod_pkg::flash_addr_t step_addr;

  // ============================================================
  // Next address, wraps inside the sample range
  // ============================================================
  always_comb
  begin
    if (reverse)
      step_addr = (flash_address == '0) ? LAST_ADDR : flash_address - 1'b1;
    else
      step_addr = (flash_address == LAST_ADDR) ? '0 : flash_address + 1'b1;
  end

  // ============================================================
  // Read FSM, one read outstanding at a time
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= ST_IDLE;
      flash_address <= '0;
      audio_sample  <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (sample_tick)
            state <= ST_REQ;
        end
        ST_REQ:
        begin
          // Hold the request through back-pressure
          if (!flash_waitrequest)
          begin
            state         <= ST_WAIT;
            flash_address <= step_addr;
          end
        end
        ST_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            state        <= ST_IDLE;
            audio_sample <= flash_readdata[31:24];
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Ticks outside ST_IDLE are dropped
  assign flash_read = (state == ST_REQ);

endmodule

// File: source/hex_period_display.sv
`timescale 1ns/1ps
`include "ipod_defs.svh"

module hex_period_display #(
  parameter int REFRESH_CYCLES = `IPOD_REFRESH_CYCLES
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  ipod_pkg::sample_period_t sample_period,
  output ipod_pkg::seg7_t          hex0,
  output ipod_pkg::seg7_t          hex1,
  output ipod_pkg::seg7_t          hex2,
  output ipod_pkg::seg7_t          hex3,
  output ipod_pkg::seg7_t          hex4,
  output ipod_pkg::seg7_t          hex5
);

  localparam int REF_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
  localparam logic [REF_W-1:0] REF_LAST = REF_W'(REFRESH_CYCLES - 1);

  logic [REF_W-1:0] ref_cnt;
  ipod_pkg::sample_period_t shown_period;

  // Hex nibble to active-low segments, gfedcba
  function automatic ipod_pkg::seg7_t seg_decode(input logic [3:0] nib);
    ipod_pkg::seg7_t seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // ============================================================
  // Slow refresh of the shown value
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      ref_cnt      <= '0;
      shown_period <= `IPOD_DEFAULT_PERIOD;
    end
    else if (ref_cnt == REF_LAST)
    begin
      ref_cnt      <= '0;
      shown_period <= sample_period;
    end
    else
    begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  assign hex0 = seg_decode(shown_period[3:0]);
  assign hex1 = seg_decode(shown_period[7:4]);
  assign hex2 = seg_decode(shown_period[11:8]);
  assign hex3 = seg_decode(shown_period[15:12]);
  // Period is only 16 bits wide
  assign hex4 = seg_decode(4'h0);
  assign hex5 = seg_decode(4'h0);

endmodule

// File: source/ipod_pkg.sv
`include "ipod_defs.svh"

package ipod_pkg;

  // Flash word address
  typedef logic [`IPOD_ADDR_W-1:0] flash_addr_t;

  // Flash read data
  typedef logic [`IPOD_DATA_W-1:0] flash_word_t;

  // Sample period in clock cycles
  typedef logic [`IPOD_PERIOD_W-1:0] sample_period_t;

  // Audio byte sent out
  typedef logic [7:0] audio_sample_t;

  // Segments, active low, bit 0 is segment a
  typedef logic [6:0] seg7_t;

endpackage

// File: source/ipod_top.sv
`timescale 1ns/1ps
`include "ipod_defs.svh"

module ipod_top #(
  parameter int                    EVENT_CYCLES   = `IPOD_EVENT_CYCLES,
  parameter int                    REFRESH_CYCLES = `IPOD_REFRESH_CYCLES,
  parameter ipod_pkg::flash_addr_t LAST_ADDR      = 23'h7FFFF
) (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    key_up,
  input  logic                    key_down,
  input  logic                    key_default,
  input  logic                    play_enable,
  input  logic                    reverse,
  output logic                    flash_read,
  output ipod_pkg::flash_addr_t   flash_address,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  ipod_pkg::flash_word_t   flash_readdata,
  output ipod_pkg::audio_sample_t audio_sample,
  output ipod_pkg::seg7_t         hex0,
  output ipod_pkg::seg7_t         hex1,
  output ipod_pkg::seg7_t         hex2,
  output ipod_pkg::seg7_t         hex3,
  output ipod_pkg::seg7_t         hex4,
  output ipod_pkg::seg7_t         hex5
);

  logic speed_up;
  logic speed_down;
  logic speed_default;
  logic sample_tick;
  ipod_pkg::sample_period_t sample_period;

  // ============================================================
  // Rate control path
  // ============================================================
  key_event_gen #(.EVENT_CYCLES(EVENT_CYCLES)) key_event_gen_i (
    .CLK_50M(CLK_50M), .rst(rst),
    .key_up(key_up), .key_down(key_down), .key_default(key_default),
    .speed_up(speed_up), .speed_down(speed_down), .speed_default(speed_default)
  );

  speed_ctrl speed_ctrl_i (
    .CLK_50M(CLK_50M), .rst(rst),
    .speed_up(speed_up), .speed_down(speed_down), .speed_default(speed_default),
    .sample_period(sample_period)
  );

  // ============================================================
  // Sample fetch path
  // ============================================================
  sample_tick_gen sample_tick_gen_i (
    .CLK_50M(CLK_50M), .rst(rst), .play_enable(play_enable),
    .sample_period(sample_period), .sample_tick(sample_tick)
  );

  flash_sample_reader #(.LAST_ADDR(LAST_ADDR)) flash_sample_reader_i (
    .CLK_50M(CLK_50M), .rst(rst), .sample_tick(sample_tick), .reverse(reverse),
    .flash_waitrequest(flash_waitrequest), .flash_readdatavalid(flash_readdatavalid),
    .flash_readdata(flash_readdata), .flash_read(flash_read),
    .flash_address(flash_address), .audio_sample(audio_sample)
  );

  hex_period_display #(.REFRESH_CYCLES(REFRESH_CYCLES)) hex_period_display_i (
    .CLK_50M(CLK_50M), .rst(rst), .sample_period(sample_period),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

endmodule

// File: source/key_event_gen.sv
`timescale 1ns/1ps
`include "ipod_defs.svh"

module key_event_gen #(
  parameter int EVENT_CYCLES = `IPOD_EVENT_CYCLES
) (
  input  logic CLK_50M,
  input  logic rst,
  input  logic key_up,
  input  logic key_down,
  input  logic key_default,
  output logic speed_up,
  output logic speed_down,
  output logic speed_default
);

  localparam int WIN_W = (EVENT_CYCLES > 1) ? $clog2(EVENT_CYCLES) : 1;
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(EVENT_CYCLES - 1);

  // Bit 0 up, bit 1 down, bit 2 default
  logic [2:0] sync_q1;
  logic [2:0] sync_q2;
  logic [WIN_W-1:0] win_cnt;
  logic win_wrap;

  // ============================================================
  // Key synchronizers, keys are active low
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end
    else
    begin
      sync_q1 <= ~{key_default, key_down, key_up};
      sync_q2 <= sync_q1;
    end
  end

  // ============================================================
  // Event window and rate-limited pulses
  // ============================================================
  assign win_wrap = (win_cnt == WIN_LAST);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      win_cnt    <= '0;
      speed_up   <= 1'b0;
      speed_down <= 1'b0;
    end
    else
    begin
      win_cnt    <= win_wrap ? '0 : win_cnt + 1'b1;
      // At most one step per window
      speed_up   <= win_wrap & sync_q2[0];
      speed_down <= win_wrap & sync_q2[1];
    end
  end

  // Default restore is a plain level
  assign speed_default = sync_q2[2];

endmodule

// File: source/sample_tick_gen.sv
`timescale 1ns/1ps

module sample_tick_gen (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     play_enable,
  input  ipod_pkg::sample_period_t sample_period,
  output logic                     sample_tick
);

  ipod_pkg::sample_period_t count;

  // ============================================================
  // Period down-counter
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (play_enable)
    begin
      // New period is picked up only here
      if (count == '0)
        count <= sample_period - 1'b1;
      else
        count <= count - 1'b1;
    end
  end

  // One tick per period while playing
  assign sample_tick = play_enable && (count == '0);

endmodule

// File: source/speed_ctrl.sv
`timescale 1ns/1ps
`include "ipod_defs.svh"

module speed_ctrl (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    speed_up,
  input  logic                    speed_down,
  input  logic                    speed_default,
  output ipod_pkg::sample_period_t sample_period
);

  localparam ipod_pkg::sample_period_t DEF_P  = `IPOD_DEFAULT_PERIOD;
  localparam ipod_pkg::sample_period_t STEP   = `IPOD_SPEED_STEP;
  localparam ipod_pkg::sample_period_t MIN_P  = `IPOD_MIN_PERIOD;
  localparam ipod_pkg::sample_period_t MAX_P  = `IPOD_MAX_PERIOD;

  always_ff @(posedge CLK_50M)
  begin
    if (rst || speed_default)
    begin
      sample_period <= DEF_P;
    end
    else if (speed_up && !speed_down)
    begin
      // Shorter period means faster playback
      if (sample_period < MIN_P + STEP)
        sample_period <= MIN_P;
      else
        sample_period <= sample_period - STEP;
    end
    else if (speed_down && !speed_up)
    begin
      if (sample_period > MAX_P - STEP)
        sample_period <= MAX_P;
      else
        sample_period <= sample_period + STEP;
    end
  end

endmodule

// File: verif/ipod_assert.sv
`timescale 1ns/1ps

module ipod_assert (
  input logic                  CLK_50M,
  input logic                  rst,
  input logic                  flash_read,
  input ipod_pkg::flash_addr_t flash_address,
  input logic                  flash_waitrequest,
  input logic                  flash_readdatavalid,
  input logic                  speed_up,
  input logic                  speed_down
);

  logic read_pending;

  // Accepted read still waiting for its data
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      read_pending <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      read_pending <= 1'b1;
    else if (flash_readdatavalid)
      read_pending <= 1'b0;
  end

  // ============================================================
  // Flash port rules
  // ============================================================
  hold_during_wait: assert property (@(posedge CLK_50M) disable iff (rst)
    (flash_read && flash_waitrequest) |=> (flash_read && $stable(flash_address)))
    else $error("flash request changed while waitrequest was high");

  one_outstanding: assert property (@(posedge CLK_50M) disable iff (rst)
    read_pending |-> !flash_read)
    else $error("new flash read issued before readdatavalid");

  // ============================================================
  // Event pulses last one cycle
  // ============================================================
  up_single: assert property (@(posedge CLK_50M) disable iff (rst)
    speed_up |=> !speed_up)
    else $error("speed_up high for two cycles");

  down_single: assert property (@(posedge CLK_50M) disable iff (rst)
    speed_down |=> !speed_down)
    else $error("speed_down high for two cycles");

endmodule

bind flash_sample_reader ipod_assert reader_assert_i (
  .CLK_50M(CLK_50M), .rst(rst), .flash_read(flash_read), .flash_address(flash_address),
  .flash_waitrequest(flash_waitrequest), .flash_readdatavalid(flash_readdatavalid),
  .speed_up(1'b0), .speed_down(1'b0)
);

bind key_event_gen ipod_assert key_assert_i (
  .CLK_50M(CLK_50M), .rst(rst), .flash_read(1'b0), .flash_address('0),
  .flash_waitrequest(1'b0), .flash_readdatavalid(1'b0),
  .speed_up(speed_up), .speed_down(speed_down)
);

// File: verif/ipod_patterns.txt
# op cycles expected_period
# op is hold_up, hold_down, hold_default, play or reverse, period in decimal
hold_down 150 644
hold_up 100 624
hold_default 20 614
hold_up 2800 64
play 1200 64
reverse 1200 64
play 600 64
hold_down 20000 4000
hold_up 500 3900
hold_default 20 614

// File: verif/ipod_tb.sv
`timescale 1ns/1ps
`include "ipod_defs.svh"

module ipod_tb;

  localparam int EVENT_CYCLES = 50;
  localparam int REFRESH_CYCLES = 40;
  localparam ipod_pkg::flash_addr_t LAST_ADDR = 23'd7;
  // Sync delay, period update and one full refresh
  localparam int SETTLE_CYCLES = REFRESH_CYCLES + 8;
  localparam int IDLE_CYCLES = 100;

  logic CLK_50M = 1'b0;
  logic rst;
  logic key_up;
  logic key_down;
  logic key_default;
  logic play_enable;
  logic reverse;
  logic flash_read;
  ipod_pkg::flash_addr_t flash_address;
  logic flash_waitrequest;
  logic flash_readdatavalid;
  ipod_pkg::flash_word_t flash_readdata;
  ipod_pkg::audio_sample_t audio_sample;
  ipod_pkg::seg7_t hex0;
  ipod_pkg::seg7_t hex1;
  ipod_pkg::seg7_t hex2;
  ipod_pkg::seg7_t hex3;
  ipod_pkg::seg7_t hex4;
  ipod_pkg::seg7_t hex5;

  // Flash model state
  logic [31:0] rand_state;
  int data_wait;
  ipod_pkg::flash_addr_t held_addr;
  ipod_pkg::flash_addr_t exp_addr;
  ipod_pkg::audio_sample_t exp_sample;
  ipod_pkg::audio_sample_t last_sample;
  logic step_due;
  logic sample_due;
  logic busy;
  logic rev_q;
  int read_count;

  int period_errors;
  int sample_errors;
  int addr_errors;
  int other_errors;
  int cycle_count;
  int cycle_limit;
  int cycle_sum;
  int fd;
  int n;
  int cyc_val;
  int per_val;
  logic [8*16-1:0] op_word;
  logic [8*80-1:0] line_buf;
  logic [8*16-1:0] op_q[$];
  int cyc_q[$];
  int per_q[$];

  ipod_top #(
    .EVENT_CYCLES(EVENT_CYCLES), .REFRESH_CYCLES(REFRESH_CYCLES), .LAST_ADDR(LAST_ADDR)
  ) dut_i (.*);

  always #10 CLK_50M = ~CLK_50M;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Sample range wraps at both ends
  function automatic ipod_pkg::flash_addr_t step_address(input ipod_pkg::flash_addr_t a,
                                                         input logic rev);
    int span;
    span = int'(LAST_ADDR) + 1;
    if (rev)
      return ipod_pkg::flash_addr_t'((int'(a) + span - 1) % span);
    return ipod_pkg::flash_addr_t'((int'(a) + 1) % span);
  endfunction

  // Top byte A+16 over a fill that depends on the whole address
  function automatic ipod_pkg::flash_word_t flash_word(input ipod_pkg::flash_addr_t a);
    return {8'(a + 16), {1'b0, a} ^ 24'h5A5A5A};
  endfunction

  // Active-low gfedcba pattern back to {valid, nibble}
  function automatic logic [4:0] seg_nibble(input ipod_pkg::seg7_t seg);
    case (seg)
      7'h40: return 5'h10;
      7'h79: return 5'h11;
      7'h24: return 5'h12;
      7'h30: return 5'h13;
      7'h19: return 5'h14;
      7'h12: return 5'h15;
      7'h02: return 5'h16;
      7'h78: return 5'h17;
      7'h00: return 5'h18;
      7'h10: return 5'h19;
      7'h08: return 5'h1A;
      7'h03: return 5'h1B;
      7'h46: return 5'h1C;
      7'h21: return 5'h1D;
      7'h06: return 5'h1E;
      7'h0E: return 5'h1F;
      default: return 5'h00;
    endcase
  endfunction

  // ============================================================
  // Compare tasks
  // ============================================================
  task automatic check_period(input ipod_pkg::sample_period_t got,
                              input ipod_pkg::sample_period_t exp);
    if (got !== exp)
    begin
      period_errors++;
      $display("FAILED at %0t: sample period %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_sample(input ipod_pkg::audio_sample_t got,
                              input ipod_pkg::audio_sample_t exp);
    if (got !== exp)
    begin
      sample_errors++;
      $display("FAILED at %0t: audio sample %0h, expected %0h", $time, got, exp);
    end
  endtask

  task automatic check_addr(input ipod_pkg::flash_addr_t got,
                            input ipod_pkg::flash_addr_t exp);
    if (got !== exp)
    begin
      addr_errors++;
      $display("FAILED at %0t: flash address %0h, expected %0h", $time, got, exp);
    end
  endtask

  task automatic check_display(input ipod_pkg::sample_period_t exp);
    logic [41:0] all_segs;
    logic [23:0] val;
    logic [4:0] dig;
    logic ok;
    all_segs = {hex5, hex4, hex3, hex2, hex1, hex0};
    val = '0;
    ok = 1'b1;
    for (int k = 0; k < 6; k++)
    begin
      dig = seg_nibble(all_segs[k*7 +: 7]);
      ok = ok & dig[4];
      val[k*4 +: 4] = dig[3:0];
    end
    if (!ok)
    begin
      other_errors++;
      $display("Display shows a pattern that is no hex digit at %0t", $time);
    end
    else if (val[23:16] != 8'h00)
    begin
      other_errors++;
      $display("Upper two hex digits are not zero at %0t", $time);
    end
    else
      check_period(val[15:0], exp);
  endtask

  // ============================================================
  // Stimulus tasks for the active-low keys and playback
  // ============================================================
  task automatic hold_key(input int which, input int cycles);
    @(negedge CLK_50M);
    case (which)
      0: key_up = 1'b0;
      1: key_down = 1'b0;
      default: key_default = 1'b0;
    endcase
    repeat (cycles) @(negedge CLK_50M);
    key_up = 1'b1;
    key_down = 1'b1;
    key_default = 1'b1;
    repeat (SETTLE_CYCLES) @(negedge CLK_50M);
  endtask

  task automatic play_for(input int cycles, input logic dir);
    int reads_before;
    @(negedge CLK_50M);
    reads_before = read_count;
    reverse = dir;
    play_enable = 1'b1;
    repeat (cycles) @(negedge CLK_50M);
    play_enable = 1'b0;
    if (read_count == reads_before)
    begin
      other_errors++;
      $display("No flash read happened during %0d cycles of playback", cycles);
    end
    // Let the read in flight finish
    do
    begin
      @(negedge CLK_50M);
    end
    while (flash_read || busy);
    reads_before = read_count;
    repeat (IDLE_CYCLES) @(negedge CLK_50M);
    if (read_count != reads_before)
    begin
      other_errors++;
      $display("Flash read issued while playback was disabled at %0t", $time);
    end
    check_sample(audio_sample, last_sample);
  endtask

  // ============================================================
  // Flash model with random back-pressure and latency
  // ============================================================
  always @(posedge CLK_50M)
  begin
    rev_q <= reverse;
  end

  always @(negedge CLK_50M)
  begin
    if (step_due)
    begin
      exp_addr = step_address(exp_addr, rev_q);
      step_due = 1'b0;
    end
    if (sample_due)
    begin
      check_sample(audio_sample, exp_sample);
      last_sample <= exp_sample;
      busy <= 1'b0;
      sample_due = 1'b0;
    end
    flash_readdatavalid = 1'b0;
    if (data_wait == 1)
    begin
      flash_readdatavalid = 1'b1;
      flash_readdata = flash_word(held_addr);
      sample_due = 1'b1;
    end
    if (data_wait > 0)
      data_wait = data_wait - 1;
    rand_state = next_random(rand_state);
    flash_waitrequest = (rand_state[31:30] == 2'b00);
    // Read is accepted on the coming rising edge
    if (flash_read && !flash_waitrequest)
    begin
      check_addr(flash_address, exp_addr);
      held_addr = flash_address;
      exp_sample = ipod_pkg::audio_sample_t'(exp_addr + 16);
      rand_state = next_random(rand_state);
      data_wait = 1 + rand_state[31:30];
      step_due = 1'b1;
      busy <= 1'b1;
      read_count <= read_count + 1;
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: run did not end within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial
  begin
    rst = 1'b1;
    key_up = 1'b1;
    key_down = 1'b1;
    key_default = 1'b1;
    play_enable = 1'b0;
    reverse = 1'b0;
    flash_waitrequest = 1'b0;
    flash_readdatavalid = 1'b0;
    flash_readdata = '0;
    rand_state = 32'h70270089;
    data_wait = 0;
    held_addr = '0;
    exp_addr = '0;
    exp_sample = '0;
    last_sample = '0;
    step_due = 1'b0;
    sample_due = 1'b0;
    busy = 1'b0;
    read_count = 0;
    period_errors = 0;
    sample_errors = 0;
    addr_errors = 0;
    other_errors = 0;
    cycle_count = 0;
    cycle_sum = 0;
    cycle_limit = 1000;

    fd = $fopen("verif/ipod_patterns.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("Cannot open the pattern file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fscanf(fd, "%s", op_word);
        if (n == 1 && op_word == "#")
          n = $fgets(line_buf, fd);
        else if (n == 1)
        begin
          n = $fscanf(fd, "%d %d", cyc_val, per_val);
          if (n == 2)
          begin
            op_q.push_back(op_word);
            cyc_q.push_back(cyc_val);
            per_q.push_back(per_val);
            cycle_sum += cyc_val;
          end
          else
          begin
            other_errors++;
            $display("Pattern line with operation %0s is incomplete", op_word);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 2 * cycle_sum + 1000;

    repeat (8) @(negedge CLK_50M);
    rst = 1'b0;
    repeat (SETTLE_CYCLES) @(negedge CLK_50M);
    check_display(`IPOD_DEFAULT_PERIOD);

    for (int i = 0; i < op_q.size(); i++)
    begin
      if (op_q[i] == "hold_up")
        hold_key(0, cyc_q[i]);
      else if (op_q[i] == "hold_down")
        hold_key(1, cyc_q[i]);
      else if (op_q[i] == "hold_default")
        hold_key(2, cyc_q[i]);
      else if (op_q[i] == "play")
        play_for(cyc_q[i], 1'b0);
      else if (op_q[i] == "reverse")
        play_for(cyc_q[i], 1'b1);
      else
      begin
        other_errors++;
        $display("Unknown operation %0s in the pattern file", op_q[i]);
      end
      check_display(per_q[i]);
    end

    repeat (4) @(negedge CLK_50M);
    $display("Error counts: period %0d, sample %0d, address %0d, other %0d",
             period_errors, sample_errors, addr_errors, other_errors);
    if (period_errors + sample_errors + addr_errors + other_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
